// ==== Makefile ====
TOP = lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== rtl/lsu_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_decode
    import lsu_pkg::*;
(
    input  lsu_req_t  req,
    output word_t     addr,
    output word_t     st_data,
    output byte_sel_t st_sel
);

    logic misaligned;

    always_comb begin
        addr = req.base + req.imm;
        case (req.funct3)
            MEM_BYTE, MEM_BYTE_U: begin
                st_sel  = 4'b0001 << addr[1:0];
                st_data = word_t'(req.st_value[7:0]) << {addr[1:0], 3'b000};
            end
            MEM_HALF, MEM_HALF_U: begin
                st_sel  = 4'b0011 << addr[1:0];
                st_data = word_t'(req.st_value[15:0]) << {addr[1:0], 3'b000};
            end
            default: begin
                st_sel  = 4'b1111;
                st_data = req.st_value;
            end
        endcase
    end

    always_comb begin
        case (req.funct3)
            MEM_BYTE, MEM_BYTE_U: misaligned = 1'b0;
            MEM_HALF, MEM_HALF_U: misaligned = addr[0];
            default:              misaligned = |addr[1:0];
        endcase
    end

    // no misaligned support, the port must only see naturally aligned accesses
    always_comb begin
        assert (!misaligned)
            else $error("misaligned access: addr %h funct3 %0d", addr, req.funct3);
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_load_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_load_queue
    import lsu_pkg::*;
#(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc,
    input  lsu_req_t                  req,
    input  word_t                     addr,
    input  logic [$clog2(SQ_DEPTH):0] sq_tail,
    input  logic [$clog2(SQ_DEPTH):0] sq_head,
    input  logic [SQ_DEPTH-1:0]       sq_valid,
    input  word_t [SQ_DEPTH-1:0]      sq_addr,
    input  logic                      ld_grant,
    input  logic                      ld_done,
    output logic                      lq_full,
    output logic                      ld_mem_valid,
    output mem_req_t                  ld_mem_req,
    output lq_entry_t                 inflight
);

    localparam int LQW = $clog2(LQ_DEPTH);
    localparam int SQW = $clog2(SQ_DEPTH);

    lq_entry_t           lq_q [LQ_DEPTH];
    logic [LQW:0]        head, tail;
    logic [LQW-1:0]      sel_idx, inflight_idx;
    logic [LQ_DEPTH-1:0] eligible;

    assign lq_full = (head[LQW-1:0] == tail[LQW-1:0]) && (head[LQW] != tail[LQW]);

    // ==================================================
    // ordering check against older stores
    // ==================================================
    always_comb begin
        logic [SQW:0]   span;
        logic [SQW-1:0] off;
        logic           blocked;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            // stores older than the load sit between sq head and the snapshot
            span = lq_q[i].sq_tail_snap[SQW:0] - sq_head;
            if (span > (SQW+1)'(SQ_DEPTH)) begin
                span = '0;
            end
            blocked = 1'b0;
            for (int j = 0; j < SQ_DEPTH; j++) begin
                off = SQW'(j) - sq_head[SQW-1:0];
                if (sq_valid[j] && ({1'b0, off} < span)
                        && (sq_addr[j][31:2] == lq_q[i].addr[31:2])) begin
                    blocked = 1'b1;
                end
            end
            eligible[i] = lq_q[i].valid && !lq_q[i].done && !blocked;
        end
    end

    // oldest eligible, walking from head
    always_comb begin
        logic [LQW-1:0] idx;
        sel_idx      = '0;
        ld_mem_valid = 1'b0;
        for (int k = 0; k < LQ_DEPTH; k++) begin
            idx = head[LQW-1:0] + LQW'(k);
            if (!ld_mem_valid && eligible[idx]) begin
                sel_idx      = idx;
                ld_mem_valid = 1'b1;
            end
        end
        ld_mem_req = '{addr: lq_q[sel_idx].addr, data: '0, sel: 4'b1111, we: 1'b0};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < LQ_DEPTH; i++) begin
                lq_q[i].valid <= 1'b0;
                lq_q[i].done  <= 1'b0;
            end
        end else begin
            if (alloc) begin
                lq_q[tail[LQW-1:0]] <= '{valid: 1'b1, done: 1'b0, addr: addr,
                                         funct3: req.funct3, rd: req.rd, tag: req.tag,
                                         sq_tail_snap: SQ_PTR_MAX_W'(sq_tail)};
                tail <= tail + 1'b1;
            end
            if (ld_grant) begin
                lq_q[sel_idx].done <= 1'b1;
            end
            if (ld_done) begin
                lq_q[inflight_idx].valid <= 1'b0;
            end
            // loads finish out of order, head skips one freed slot per cycle
            if ((head != tail) && !lq_q[head[LQW-1:0]].valid) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_grant) begin
            inflight_idx <= sel_idx;
            inflight     <= lq_q[sel_idx];
        end
    end

    a_grant_needs_request: assert property (
        @(posedge clk) disable iff (rst) ld_grant |-> ld_mem_valid
    );

endmodule

`default_nettype wire

// ==== rtl/lsu_load_result.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_load_result
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_done,
    input  word_t      rdata,
    input  lq_entry_t  inflight,
    output logic       ld_valid,
    output ld_result_t ld_out
);

    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    word_t       ext;

    always_comb begin
        lane_b = rdata[{inflight.addr[1:0], 3'b000} +: 8];
        lane_h = inflight.addr[1] ? rdata[31:16] : rdata[15:0];
        case (inflight.funct3)
            MEM_BYTE:   ext = {{24{lane_b[7]}}, lane_b};
            MEM_BYTE_U: ext = {24'b0, lane_b};
            MEM_HALF:   ext = {{16{lane_h[15]}}, lane_h};
            MEM_HALF_U: ext = {16'b0, lane_h};
            default:    ext = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= ld_done;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_done) begin
            ld_out <= '{rd: inflight.rd, tag: inflight.tag, data: ext};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_mem_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_port
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ld_mem_valid,
    input  logic      st_mem_valid,
    input  mem_req_t  ld_mem_req,
    input  mem_req_t  st_mem_req,
    output logic      ld_grant,
    output logic      st_grant,
    output logic      ld_done,
    output logic      st_ack,
    output word_t     rdata,
    output logic      cyc,
    output logic      stb,
    output logic      we,
    output word_t     adr,
    output word_t     dat_w,
    output byte_sel_t sel,
    input  word_t     dat_r,
    input  logic      ack
);

    mem_state_e state;
    mem_req_t   pick;

    // loads win in idle
    assign ld_grant = (state == IDLE) && ld_mem_valid;
    assign st_grant = (state == IDLE) && st_mem_valid && !ld_mem_valid;
    assign pick     = ld_grant ? ld_mem_req : st_mem_req;

    assign ld_done = (state == LOAD_BUS) && ack;
    assign st_ack  = (state == STORE_BUS) && ack;
    assign rdata   = dat_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cyc   <= 1'b0;
            stb   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ld_grant || st_grant) begin
                        state <= ld_grant ? LOAD_BUS : STORE_BUS;
                        cyc   <= 1'b1;
                        stb   <= 1'b1;
                    end
                end
                LOAD_BUS, STORE_BUS: begin
                    if (ack) begin
                        state <= IDLE;
                        cyc   <= 1'b0;
                        stb   <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // bus payload loaded only at the start of a cycle
    always_ff @(posedge clk) begin
        if (ld_grant || st_grant) begin
            adr   <= pick.addr;
            dat_w <= pick.data;
            sel   <= pick.sel;
            we    <= pick.we;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb |-> cyc);

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_sel_t;
    typedef logic [4:0]  rob_tag_t;
    typedef logic [4:0]  reg_idx_t;

    // wide enough for a wrap-bit pointer of an 8 entry store queue
    localparam int SQ_PTR_MAX_W = 4;

    typedef enum logic [2:0] {
        MEM_BYTE   = 3'd0,
        MEM_HALF   = 3'd1,
        MEM_WORD   = 3'd2,
        MEM_BYTE_U = 3'd4,
        MEM_HALF_U = 3'd5
    } mem_funct3_e;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_BUS,
        STORE_BUS
    } mem_state_e;

    typedef struct packed {
        logic        is_store;
        mem_funct3_e funct3;
        word_t       base;
        word_t       st_value;
        word_t       imm;
        reg_idx_t    rd;
        rob_tag_t    tag;
    } lsu_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    done;
        word_t                   addr;
        mem_funct3_e             funct3;
        reg_idx_t                rd;
        rob_tag_t                tag;
        logic [SQ_PTR_MAX_W-1:0] sq_tail_snap;
    } lq_entry_t;

    typedef struct packed {
        logic      valid;
        logic      committed;
        word_t     addr;
        word_t     data;
        byte_sel_t sel;
    } sq_entry_t;

    typedef struct packed {
        word_t     addr;
        word_t     data;
        byte_sel_t sel;
        logic      we;
    } mem_req_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
        word_t    data;
    } ld_result_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_store_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_store_queue
    import lsu_pkg::*;
#(
    parameter int SQ_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc,
    input  word_t                     addr,
    input  word_t                     st_data,
    input  byte_sel_t                 st_sel,
    input  logic                      st_commit,
    input  logic                      st_grant,
    input  logic                      st_ack,
    output logic                      sq_full,
    output logic [$clog2(SQ_DEPTH):0] sq_tail,
    output logic [$clog2(SQ_DEPTH):0] sq_head,
    output logic [SQ_DEPTH-1:0]       sq_valid,
    output word_t [SQ_DEPTH-1:0]      sq_addr,
    output logic                      st_mem_valid,
    output mem_req_t                  st_mem_req
);

    localparam int SQW = $clog2(SQ_DEPTH);

    sq_entry_t      sq_q [SQ_DEPTH];
    logic [SQW:0]   head, tail, cmt;
    logic [SQW-1:0] head_idx;
    logic           on_bus;

    assign head_idx = head[SQW-1:0];
    assign sq_full  = (head_idx == tail[SQW-1:0]) && (head[SQW] != tail[SQW]);
    assign sq_tail  = tail;
    assign sq_head  = head;

    always_comb begin
        for (int j = 0; j < SQ_DEPTH; j++) begin
            sq_valid[j] = sq_q[j].valid;
            sq_addr[j]  = sq_q[j].addr;
        end
    end

    // head drains once committed, one bus cycle at a time
    assign st_mem_valid = sq_q[head_idx].valid && sq_q[head_idx].committed && !on_bus;

    always_comb begin
        st_mem_req = '{addr: sq_q[head_idx].addr, data: sq_q[head_idx].data,
                       sel: sq_q[head_idx].sel, we: 1'b1};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head   <= '0;
            tail   <= '0;
            cmt    <= '0;
            on_bus <= 1'b0;
            for (int j = 0; j < SQ_DEPTH; j++) begin
                sq_q[j].valid     <= 1'b0;
                sq_q[j].committed <= 1'b0;
            end
        end else begin
            if (alloc) begin
                sq_q[tail[SQW-1:0]] <= '{valid: 1'b1, committed: 1'b0, addr: addr,
                                         data: st_data, sel: st_sel};
                tail <= tail + 1'b1;
            end
            if (st_commit) begin
                sq_q[cmt[SQW-1:0]].committed <= 1'b1;
                cmt <= cmt + 1'b1;
            end
            if (st_grant) begin
                on_bus <= 1'b1;
            end
            if (st_ack) begin
                sq_q[head_idx].valid     <= 1'b0;
                sq_q[head_idx].committed <= 1'b0;
                head   <= head + 1'b1;
                on_bus <= 1'b0;
            end
        end
    end

    a_commit_hits_store: assert property (
        @(posedge clk) disable iff (rst)
        st_commit |-> sq_q[cmt[SQW-1:0]].valid && !sq_q[cmt[SQW-1:0]].committed
    );

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_top
    import lsu_pkg::*;
#(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  lsu_req_t   req,
    input  logic       req_valid,
    output logic       req_ready,
    input  logic       st_commit,
    output logic       ld_valid,
    output ld_result_t ld_out,
    output logic       cyc,
    output logic       stb,
    output logic       we,
    output word_t      adr,
    output word_t      dat_w,
    output byte_sel_t  sel,
    input  word_t      dat_r,
    input  logic       ack
);

    word_t                     addr, st_data, rdata;
    byte_sel_t                 st_sel;
    logic                      ld_alloc, st_alloc, lq_full, sq_full;
    logic [$clog2(SQ_DEPTH):0] sq_tail, sq_head;
    logic [SQ_DEPTH-1:0]       sq_valid;
    word_t [SQ_DEPTH-1:0]      sq_addr;
    logic                      ld_mem_valid, st_mem_valid;
    mem_req_t                  ld_mem_req, st_mem_req;
    logic                      ld_grant, st_grant, ld_done, st_ack;
    lq_entry_t                 inflight;

    assign req_ready = req.is_store ? !sq_full : !lq_full;
    assign ld_alloc  = req_valid && req_ready && !req.is_store;
    assign st_alloc  = req_valid && req_ready && req.is_store;

    lsu_decode u_decode (
        .req, .addr, .st_data, .st_sel
    );

    lsu_load_queue #(
        .LQ_DEPTH (LQ_DEPTH),
        .SQ_DEPTH (SQ_DEPTH)
    ) u_load_queue (
        .clk, .rst,
        .alloc (ld_alloc),
        .req, .addr,
        .sq_tail, .sq_head, .sq_valid, .sq_addr,
        .ld_grant, .ld_done, .lq_full,
        .ld_mem_valid, .ld_mem_req, .inflight
    );

    lsu_store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_store_queue (
        .clk, .rst,
        .alloc (st_alloc),
        .addr, .st_data, .st_sel,
        .st_commit, .st_grant, .st_ack,
        .sq_full, .sq_tail, .sq_head, .sq_valid, .sq_addr,
        .st_mem_valid, .st_mem_req
    );

    lsu_mem_port u_mem_port (
        .clk, .rst,
        .ld_mem_valid, .st_mem_valid, .ld_mem_req, .st_mem_req,
        .ld_grant, .st_grant, .ld_done, .st_ack, .rdata,
        .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack
    );

    lsu_load_result u_load_result (
        .clk, .rst, .ld_done, .rdata, .inflight, .ld_valid, .ld_out
    );

endmodule

`default_nettype wire

// ==== verification/lsu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
;

    localparam int LQ_DEPTH = 4;
    localparam int SQ_DEPTH = 4;
    localparam int TIMEOUT  = 300;

    logic       clk;
    logic       rst;
    lsu_req_t   req;
    logic       req_valid;
    logic       req_ready;
    logic       st_commit;
    logic       ld_valid;
    ld_result_t ld_out;
    logic       cyc, stb, we, ack, stall;
    word_t      adr, dat_w, dat_r;
    byte_sel_t  sel;

    word_t    ref_mem [64];
    word_t    exp_data [32];
    reg_idx_t exp_rd [32];
    logic     outstanding [32];
    int       checks;
    int       errors;
    int       uncommitted;
    rob_tag_t next_tag;

    lsu_top #(
        .LQ_DEPTH (LQ_DEPTH),
        .SQ_DEPTH (SQ_DEPTH)
    ) UUT (
        .clk, .rst, .req, .req_valid, .req_ready, .st_commit, .ld_valid, .ld_out,
        .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack
    );

    wb_mem_model u_mem (
        .clk, .rst, .stall, .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            $display("MISMATCH %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================
    function automatic int access_bytes(input mem_funct3_e f);
        case (f)
            MEM_BYTE, MEM_BYTE_U: return 1;
            MEM_HALF, MEM_HALF_U: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic word_t load_expect(input word_t a, input mem_funct3_e f);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[a[7:2]] >> (8 * int'(a[1:0]));
        b = w[7:0];
        h = w[15:0];
        case (f)
            MEM_BYTE:   return {{24{b[7]}}, b};
            MEM_BYTE_U: return {24'h0, b};
            MEM_HALF:   return {{16{h[15]}}, h};
            MEM_HALF_U: return {16'h0, h};
            default:    return ref_mem[a[7:2]];
        endcase
    endfunction

    task automatic store_ref(input word_t a, input mem_funct3_e f, input word_t v);
        int lane;
        for (int k = 0; k < access_bytes(f); k++) begin
            lane = int'(a[1:0]) + k;
            ref_mem[a[7:2]][8*lane +: 8] = v[8*k +: 8];
        end
    endtask

    // results are checked as they come back
    always @(negedge clk) begin
        if (!rst && ld_valid) begin
            if (!outstanding[ld_out.tag]) begin
                $display("unexpected load result for tag %0d", ld_out.tag);
                errors++;
            end else begin
                check("ld_out.data", ld_out.data, exp_data[ld_out.tag]);
                check("ld_out.rd", word_t'(ld_out.rd), word_t'(exp_rd[ld_out.tag]));
                outstanding[ld_out.tag] = 1'b0;
            end
        end
    end

    // ==================================================
    // drivers
    // ==================================================
    task automatic issue(input logic st, input mem_funct3_e f, input word_t a,
                         input word_t v, input logic auto_commit, output rob_tag_t tag);
        lsu_req_t r;
        int       waited;
        logic     taken;
        r.is_store = st;
        r.funct3   = f;
        r.base     = $urandom;
        r.imm      = a - r.base;
        r.st_value = v;
        r.tag      = next_tag;
        r.rd       = reg_idx_t'(next_tag ^ 5'h15);
        tag        = next_tag;
        next_tag++;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            req       = r;
            req_valid = 1'b1;
            st_commit = 1'b0;
            #1;
            if (req_ready) begin
                taken = 1'b1;
                if (st) begin
                    store_ref(a, f, v);
                end else begin
                    exp_data[r.tag]    = load_expect(a, f);
                    exp_rd[r.tag]      = r.rd;
                    outstanding[r.tag] = 1'b1;
                end
            end else begin
                if (auto_commit && uncommitted > 0) begin
                    st_commit = 1'b1;
                    uncommitted--;
                end
                waited++;
                if (waited > TIMEOUT) begin
                    $display("request with tag %0d was never accepted", r.tag);
                    errors++;
                    break;
                end
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        st_commit = 1'b0;
        if (taken && st) begin
            uncommitted++;
        end
    endtask

    task automatic commit_one();
        @(negedge clk);
        st_commit = 1'b1;
        uncommitted--;
        @(negedge clk);
        st_commit = 1'b0;
    endtask

    task automatic wait_result(input rob_tag_t tag);
        int waited;
        waited = 0;
        while (outstanding[tag]) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("no load result for tag %0d before timeout", tag);
                errors++;
                break;
            end
        end
    endtask

    task automatic wait_all();
        int waited;
        int busy;
        waited = 0;
        do begin
            busy = 0;
            for (int t = 0; t < 32; t++) begin
                busy += int'(outstanding[t]);
            end
            if (busy != 0) begin
                @(negedge clk);
                waited++;
            end
        end while (busy != 0 && waited <= TIMEOUT * 4);
        if (busy != 0) begin
            $display("%0d loads still outstanding after timeout", busy);
            errors++;
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic word_round_trip();
        rob_tag_t t;
        issue(1'b1, MEM_WORD, 32'h10, 32'hCAFE_1234, 1'b0, t);
        commit_one();
        issue(1'b0, MEM_WORD, 32'h10, '0, 1'b0, t);
        wait_result(t);
        $display("word round trip done, errors %0d", errors);
    endtask

    task automatic narrow_loads();
        rob_tag_t t;
        issue(1'b1, MEM_WORD, 32'h14, 32'h7A81_F480, 1'b0, t);
        commit_one();
        for (int off = 0; off < 4; off++) begin
            issue(1'b0, MEM_BYTE, 32'h14 + off, '0, 1'b0, t);
            wait_result(t);
            issue(1'b0, MEM_BYTE_U, 32'h14 + off, '0, 1'b0, t);
            wait_result(t);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(1'b0, MEM_HALF, 32'h14 + off, '0, 1'b0, t);
            wait_result(t);
            issue(1'b0, MEM_HALF_U, 32'h14 + off, '0, 1'b0, t);
            wait_result(t);
        end
        $display("byte and half loads done, errors %0d", errors);
    endtask

    task automatic partial_stores();
        rob_tag_t t;
        issue(1'b1, MEM_BYTE, 32'h21, 32'h0000_005C, 1'b0, t);
        commit_one();
        issue(1'b1, MEM_HALF, 32'h22, 32'h0000_BEEF, 1'b0, t);
        commit_one();
        issue(1'b0, MEM_WORD, 32'h20, '0, 1'b0, t);
        wait_result(t);
        $display("partial stores done, errors %0d", errors);
    endtask

    task automatic load_ordering();
        rob_tag_t t_st, t_same, t_other;
        issue(1'b1, MEM_WORD, 32'h30, 32'h1357_9BDF, 1'b0, t_st);
        issue(1'b0, MEM_WORD, 32'h30, '0, 1'b0, t_same);
        issue(1'b0, MEM_WORD, 32'h40, '0, 1'b0, t_other);
        wait_result(t_other);
        // blocked load has to stay quiet while the store waits
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (!outstanding[t_same]) begin
                $display("load returned before the older store was committed");
                errors++;
                break;
            end
        end
        commit_one();
        wait_result(t_same);
        $display("ordering done, errors %0d", errors);
    endtask

    task automatic back_pressure();
        rob_tag_t t;
        stall = 1'b1;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            issue(1'b0, MEM_WORD, 32'h50 + 4 * i, '0, 1'b0, t);
        end
        @(negedge clk);
        req.is_store = 1'b0;
        #1;
        check("req_ready", word_t'(req_ready), 32'h0);
        check("cyc", word_t'(cyc), 32'h1);
        stall = 1'b0;
        wait_all();
        $display("back-pressure done, errors %0d", errors);
    endtask

    task automatic random_mix();
        mem_funct3_e ops [5] = '{MEM_BYTE, MEM_HALF, MEM_WORD, MEM_BYTE_U, MEM_HALF_U};
        mem_funct3_e f;
        logic        st;
        word_t       a;
        rob_tag_t    t;
        for (int n = 0; n < 40; n++) begin
            st = logic'($urandom_range(1, 0));
            f  = st ? ops[$urandom_range(2, 0)] : ops[$urandom_range(4, 0)];
            a  = word_t'($urandom_range(63, 0)) << 2;
            if (access_bytes(f) == 1) begin
                a += $urandom_range(3, 0);
            end else if (access_bytes(f) == 2) begin
                a += 2 * $urandom_range(1, 0);
            end
            issue(st, f, a, $urandom, 1'b1, t);
            if (uncommitted > 0 && $urandom_range(1, 0) == 1) begin
                commit_one();
            end
        end
        while (uncommitted > 0) begin
            commit_one();
        end
        wait_all();
        $display("random mix done, errors %0d", errors);
    endtask

    initial begin
        void'($urandom(84965));
        rst         = 1'b1;
        req         = '0;
        req_valid   = 1'b0;
        st_commit   = 1'b0;
        stall       = 1'b0;
        checks      = 0;
        errors      = 0;
        uncommitted = 0;
        next_tag    = '0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
        end
        for (int t = 0; t < 32; t++) begin
            outstanding[t] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        word_round_trip();
        narrow_loads();
        partial_stores();
        load_ordering();
        back_pressure();
        random_mix();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/wb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_mem_model
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  word_t     adr,
    input  word_t     dat_w,
    input  byte_sel_t sel,
    output word_t     dat_r,
    output logic      ack
);

    word_t mem [64];
    logic  busy;
    int    delay;

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
        end
    end

    // one cycle to latch the request, then 0 to 3 wait cycles
    always @(posedge clk) begin
        if (rst) begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end else if (ack) begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end else if (cyc && stb) begin
            if (!busy) begin
                busy  <= 1'b1;
                delay <= $urandom_range(3, 0);
            end else if (!stall && delay == 0) begin
                ack <= 1'b1;
                if (we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel[b]) begin
                            mem[adr[7:2]][8*b +: 8] <= dat_w[8*b +: 8];
                        end
                    end
                end else begin
                    dat_r <= mem[adr[7:2]];
                end
            end else if (delay > 0) begin
                delay <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/lsu_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_load_queue.sv
rtl/lsu_store_queue.sv
rtl/lsu_mem_port.sv
rtl/lsu_load_result.sv
rtl/lsu_top.sv
verification/wb_mem_model.sv
verification/lsu_tb.sv
